/* vlog.f */
rtl/cpu_pkg.sv
rtl/cpu_regfile.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_core.sv
sim/cpu_core_properties.sv
sim/tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu_core
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core import cpu_pkg::*; ();

   localparam int MEM_WORDS   = 64;               // Both memories, byte address bits 7:2
   localparam int RUN_TIMEOUT = 2000;             // Cycles allowed per program

   logic  clk;
   logic  rst_i;
   logic  ibus_valid_i = 1'b0;
   insn_t ibus_insn_i;
   addr_t ibus_addr_o;
   logic  ibus_ready_o;
   logic  dbus_req_o;
   logic  dbus_we_o;
   addr_t dbus_addr_o;
   word_t dbus_wdata_o;
   logic  dbus_ack_i = 1'b0;
   word_t dbus_rdata_i = '0;

   insn_t imem [MEM_WORDS];
   word_t dmem [MEM_WORDS];
   addr_t store_addr_q [$];                       // Stores in bus order
   word_t store_data_q [$];
   addr_t exp_addr_q [$];                         // Stores the ISA predicts
   word_t exp_data_q [$];
   int    prog_len = 0;
   int    ack_wait = -1;                          // Cycles left before ack, -1 when idle
   logic  heavy_stall = 1'b0;                     // Valid only one cycle in four
   int    tests_run = 0;
   int    tests_failed = 0;
   int    check_errors = 0;

   cpu_core dut0 (
      .clk          (clk),
      .rst_i        (rst_i),
      .ibus_addr_o  (ibus_addr_o),
      .ibus_ready_o (ibus_ready_o),
      .ibus_valid_i (ibus_valid_i),
      .ibus_insn_i  (ibus_insn_i),
      .dbus_req_o   (dbus_req_o),
      .dbus_we_o    (dbus_we_o),
      .dbus_addr_o  (dbus_addr_o),
      .dbus_wdata_o (dbus_wdata_o),
      .dbus_ack_i   (dbus_ack_i),
      .dbus_rdata_i (dbus_rdata_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                      // 4 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // Bus models
   //////////////////////////////////////////////////////////////////////

   function automatic word_t fill_word(input int idx);
      return {8'hc3, idx[7:0], 8'h5a, ~idx[7:0]}; // Unique per word
   endfunction

   // Instruction word follows the address shown in the same cycle
   assign ibus_insn_i = imem[ibus_addr_o[7:2]];

   always @(posedge clk) begin
      if (heavy_stall) begin
         ibus_valid_i <= ($urandom_range(3, 0) == 0);
      end else begin
         ibus_valid_i <= ($urandom_range(3, 0) != 0); // Stall about one in four
      end
   end

   always @(posedge clk) begin
      dbus_ack_i <= 1'b0;                         // Ack is a single-cycle pulse
      if (rst_i) begin
         ack_wait = -1;
         store_addr_q.delete();
         store_data_q.delete();
         for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
         end
      end else if (dbus_req_o && !dbus_ack_i) begin
         if (ack_wait < 0) begin
            ack_wait = $urandom_range(3, 0);      // New request, pick its delay
         end
         if (ack_wait == 0) begin
            ack_wait = -1;
            dbus_ack_i <= 1'b1;
            if (dbus_we_o) begin
               dmem[dbus_addr_o[7:2]] = dbus_wdata_o;
               store_addr_q.push_back(dbus_addr_o);
               store_data_q.push_back(dbus_wdata_o);
            end else begin
               dbus_rdata_i <= dmem[dbus_addr_o[7:2]];
            end
         end else begin
            ack_wait--;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Program assembly and run
   //////////////////////////////////////////////////////////////////////

   function automatic insn_t encode(input logic [3:0] op, input int rd, input int rs1,
                                    input int rs2, input int imm);
      return {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
   endfunction

   task automatic new_program();
      for (int i = 0; i < MEM_WORDS; i++) begin
         imem[i] = insn_t'(i);                    // Opcode 0, a NOP tagged with its index
      end
      prog_len = 0;
      exp_addr_q.delete();
      exp_data_q.delete();
   endtask

   task automatic emit(input insn_t insn);
      imem[prog_len] = insn;
      prog_len++;
   endtask

   task automatic expect_store(input addr_t addr, input word_t data);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
   endtask

   task automatic run_program(input string name);
      int cycles;
      int errors_before;
      emit(encode(OP_BEQ, 0, 0, 0, -1));          // Branch to itself parks the core
      errors_before = check_errors;
      @(posedge clk);
      rst_i <= 1'b1;
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);                             // Reset state, before any fetch
      if (ibus_addr_o != RESET_PC) begin
         $display("Mismatch at %0t: %s first fetch address %h, expected %h",
                  $time, name, ibus_addr_o, RESET_PC);
         check_errors++;
      end
      if (ibus_ready_o !== 1'b1) begin
         $display("Mismatch at %0t: %s ibus ready %b after reset, expected 1",
                  $time, name, ibus_ready_o);
         check_errors++;
      end
      cycles = 0;
      while ((store_addr_q.size() < exp_addr_q.size()) && (cycles < RUN_TIMEOUT)) begin
         @(posedge clk);
         cycles++;
      end
      if (store_addr_q.size() < exp_addr_q.size()) begin
         $display("%s timed out after %0d cycles with %0d of %0d stores seen",
                  name, cycles, store_addr_q.size(), exp_addr_q.size());
         check_errors++;
      end else begin
         for (int i = 0; i < exp_addr_q.size(); i++) begin
            if ((store_addr_q[i] !== exp_addr_q[i]) || (store_data_q[i] !== exp_data_q[i])) begin
               $display("Mismatch at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                        $time, name, i, store_data_q[i], store_addr_q[i],
                        exp_data_q[i], exp_addr_q[i]);
               check_errors++;
            end
         end
      end
      tests_run++;
      if (check_errors != errors_before) begin
         tests_failed++;
      end
      $display("%s: %0d stores expected, %s", name, exp_addr_q.size(),
               (check_errors == errors_before) ? "ok" : "FAIL");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic alu_ops();
      word_t a;
      word_t b;
      word_t c;
      word_t res [7];
      a = 32'h0000_1234;
      b = 32'h0000_0f0f;
      c = 32'hffff_fffb;                          // imm -5 sign-extended
      res[0] = a + b;
      res[1] = a - b;
      res[2] = a & b;
      res[3] = a | b;
      res[4] = a ^ b;
      res[5] = a + c;
      res[6] = b - a;                             // Negative result
      new_program();
      emit(encode(OP_ADDI, 1, 0, 0, 'h1234));
      emit(encode(OP_ADDI, 2, 0, 0, 'h0f0f));
      emit(encode(OP_ADDI, 3, 0, 0, -5));
      emit(encode(OP_ADD, 4, 1, 2, 0));
      emit(encode(OP_SUB, 5, 1, 2, 0));
      emit(encode(OP_AND, 6, 1, 2, 0));
      emit(encode(OP_OR, 7, 1, 2, 0));
      emit(encode(OP_XOR, 8, 1, 2, 0));
      emit(encode(OP_ADD, 9, 1, 3, 0));
      emit(encode(OP_SUB, 10, 2, 1, 0));
      for (int k = 0; k < 7; k++) begin
         emit(encode(OP_STW, 0, 0, 4 + k, 'h40 + 4 * k));
         expect_store('h40 + 4 * k, res[k]);
      end
      run_program("alu_ops");
   endtask

   task automatic dependent_chain();
      new_program();
      emit(encode(OP_ADDI, 1, 0, 0, 3));          // r1 = 3
      emit(encode(OP_ADDI, 2, 1, 0, 4));          // r2 = 7, distance 1
      emit(encode(OP_ADD, 3, 2, 1, 0));           // r3 = 10, distances 1 and 2
      emit(encode(OP_ADD, 4, 3, 3, 0));           // r4 = 20, both ports
      emit(encode(OP_ADDI, 5, 1, 0, 100));        // r5 = 103, distance 4
      emit(encode(OP_ADD, 6, 4, 5, 0));           // r6 = 123
      emit(encode(OP_STW, 0, 0, 6, 'h60));        // Store data at distance 1
      emit(encode(OP_STW, 0, 0, 3, 'h64));
      emit(encode(OP_ADDI, 7, 0, 0, 'h80));
      emit(encode(OP_STW, 0, 7, 5, 4));           // Base at distance 1
      expect_store('h60, 32'd123);
      expect_store('h64, 32'd10);
      expect_store('h84, 32'd103);
      run_program("dependent_chain");
   endtask

   task automatic load_store_pairs();
      for (int rep = 0; rep < 2; rep++) begin     // Two draws of ack delays
         new_program();
         emit(encode(OP_ADDI, 1, 0, 0, 'h77));
         emit(encode(OP_ADDI, 2, 0, 0, 'h20));    // Base address
         emit(encode(OP_STW, 0, 2, 1, 0));
         emit(encode(OP_LDW, 3, 2, 0, 0));        // Reads back 0x77
         emit(encode(OP_ADDI, 4, 3, 0, 1));       // Load-use
         emit(encode(OP_STW, 0, 2, 4, 4));
         emit(encode(OP_LDW, 5, 2, 0, 8));        // Untouched word, fill pattern
         emit(encode(OP_ADD, 6, 5, 4, 0));
         emit(encode(OP_STW, 0, 2, 6, 12));
         emit(encode(OP_STW, 0, 2, 3, -4));       // Negative offset
         expect_store('h20, 32'h77);
         expect_store('h24, 32'h78);
         expect_store('h2c, fill_word('h28 / 4) + 32'h78);
         expect_store('h1c, 32'h77);
         run_program("load_store_pairs");
      end
   endtask

   task automatic branch_paths();
      new_program();
      emit(encode(OP_ADDI, 1, 0, 0, 5));
      emit(encode(OP_ADDI, 2, 0, 0, 5));
      emit(encode(OP_BEQ, 0, 1, 2, 1));           // Taken, skips the next word
      emit(encode(OP_STW, 0, 0, 1, 'h90));        // Wrong path, must not store
      emit(encode(OP_ADDI, 3, 0, 0, 9));
      emit(encode(OP_BEQ, 0, 1, 3, 1));           // 5 vs 9 falls through
      emit(encode(OP_STW, 0, 0, 3, 'h94));
      emit(encode(OP_ADDI, 4, 0, 0, 0));          // Loop counter
      emit(encode(OP_ADDI, 5, 0, 0, 3));          // Loop limit
      emit(encode(OP_ADDI, 4, 4, 0, 1));          // Loop head at word 9
      emit(encode(OP_STW, 0, 0, 4, 'ha0));
      emit(encode(OP_BEQ, 0, 4, 5, 1));           // Exit to word 13
      emit(encode(OP_BEQ, 0, 0, 0, -4));          // Back to word 9
      emit(encode(OP_STW, 0, 0, 5, 'ha4));
      expect_store('h94, 32'd9);
      for (int i = 1; i <= 3; i++) begin
         expect_store('ha0, i);
      end
      expect_store('ha4, 32'd3);
      run_program("branch_paths");
   endtask

   task automatic r0_writes();
      for (int pass = 0; pass < 2; pass++) begin
         heavy_stall = (pass == 1);               // Same program, starved fetch
         new_program();
         emit(encode(OP_ADDI, 0, 0, 0, 55));      // Lost
         emit(encode(OP_ADD, 1, 0, 0, 0));
         emit(encode(OP_ADDI, 2, 0, 0, 'h30));
         emit(encode(OP_STW, 0, 2, 0, 0));
         emit(encode(OP_STW, 0, 2, 1, 4));
         emit(encode(OP_ADDI, 3, 0, 0, -1));
         emit(encode(OP_STW, 0, 2, 3, 8));
         emit(encode(OP_LDW, 0, 2, 0, 8));        // Load into r0, also lost
         emit(encode(OP_STW, 0, 2, 0, 12));
         emit(encode(OP_ADD, 4, 3, 0, 0));
         emit(encode(OP_STW, 0, 2, 4, 16));
         expect_store('h30, 32'h0);
         expect_store('h34, 32'h0);
         expect_store('h38, 32'hffff_ffff);
         expect_store('h3c, 32'h0);
         expect_store('h40, 32'hffff_ffff);
         run_program(pass == 1 ? "r0_writes heavy stall" : "r0_writes");
      end
      heavy_stall = 1'b0;
   endtask

   initial begin
      rst_i <= 1'b1;
      void'($urandom(32'ha4136b75));
      new_program();
      alu_ops();
      dependent_chain();
      load_store_pairs();
      branch_paths();
      r0_writes();
      $display("Runs %0d, failed %0d, check errors %0d", tests_run, tests_failed, check_errors);
      if (check_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* sim/cpu_core_properties.sv */
`timescale 1ns/100ps

module cpu_core_properties import cpu_pkg::*; (
   input logic  clk,
   input logic  rst_i,
   input logic  ibus_valid_i,
   input logic  ibus_ready_i,
   input addr_t ibus_addr_i,
   input logic  dbus_req_i,
   input logic  dbus_we_i,
   input addr_t dbus_addr_i,
   input word_t dbus_wdata_i,
   input logic  dbus_ack_i
);

   // Quiet data bus and ready fetch at the reset PC
   reset_state: assert property (@(posedge clk)
      rst_i |=> !dbus_req_i && ibus_ready_i && (ibus_addr_i == RESET_PC))
      else $error("core not in its reset state after reset");

   // Request fields frozen until the ack pulse
   req_held: assert property (@(posedge clk) disable iff (rst_i)
      dbus_req_i && !dbus_ack_i |=> dbus_req_i && $stable(dbus_we_i)
                                    && $stable(dbus_addr_i) && $stable(dbus_wdata_i))
      else $error("data bus request changed before ack");

   ibus_addr_held: assert property (@(posedge clk) disable iff (rst_i)
      ibus_valid_i && !ibus_ready_i |=> $stable(ibus_addr_i))
      else $error("fetch address moved while instruction was refused");

endmodule

bind cpu_core cpu_core_properties props0 (
   .clk          (clk),
   .rst_i        (rst_i),
   .ibus_valid_i (ibus_valid_i),
   .ibus_ready_i (ibus_ready_o),
   .ibus_addr_i  (ibus_addr_o),
   .dbus_req_i   (dbus_req_o),
   .dbus_we_i    (dbus_we_o),
   .dbus_addr_i  (dbus_addr_o),
   .dbus_wdata_i (dbus_wdata_o),
   .dbus_ack_i   (dbus_ack_i)
);

/* rtl/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   // Instruction bus
   output addr_t ibus_addr_o,
   output logic  ibus_ready_o,
   input  logic  ibus_valid_i,
   input  insn_t ibus_insn_i,
   // Data bus
   output logic  dbus_req_o,
   output logic  dbus_we_o,
   output addr_t dbus_addr_o,
   output word_t dbus_wdata_o,
   input  logic  dbus_ack_i,
   input  word_t dbus_rdata_i
);

   logic     fd_valid;                            // Fetch to decode
   insn_t    fd_insn;
   addr_t    fd_pc;
   logic     fd_ready;
   logic     br_taken;                            // Redirect pulse
   addr_t    br_target;
   reg_idx_t rs1_addr;                            // Operand reads
   reg_idx_t rs2_addr;
   word_t    rs1_data;
   word_t    rs2_data;
   logic     dx_valid;                            // Decode to execute
   alu_op_t  dx_alu_op;
   word_t    dx_op_a;
   word_t    dx_op_b;
   word_t    dx_store_data;
   reg_idx_t dx_rd;
   logic     dx_wb_en;
   logic     dx_load;
   logic     dx_store;
   logic     dx_ready;
   logic     wb_we;                               // Write-back
   reg_idx_t wb_addr;
   word_t    wb_data;

   //////////////////////////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////////////////////////

   cpu_regfile regfile0 (
      .clk        (clk),        .rst_i      (rst_i),
      .rs1_addr_i (rs1_addr),   .rs2_addr_i (rs2_addr),
      .we_i       (wb_we),      .waddr_i    (wb_addr),   .wdata_i (wb_data),
      .rs1_data_o (rs1_data),   .rs2_data_o (rs2_data)
   );

   //////////////////////////////////////////////////////////////////////
   // Pipeline stages
   //////////////////////////////////////////////////////////////////////

   cpu_fetch fetch0 (
      .clk          (clk),          .rst_i        (rst_i),
      .ibus_valid_i (ibus_valid_i), .ibus_insn_i  (ibus_insn_i),
      .ibus_addr_o  (ibus_addr_o),  .ibus_ready_o (ibus_ready_o),
      .fd_ready_i   (fd_ready),     .fd_valid_o   (fd_valid),
      .fd_insn_o    (fd_insn),      .fd_pc_o      (fd_pc),
      .br_taken_i   (br_taken),     .br_target_i  (br_target)
   );

   cpu_decode decode0 (
      .clk             (clk),           .rst_i      (rst_i),
      .fd_valid_i      (fd_valid),      .fd_insn_i  (fd_insn),
      .fd_pc_i         (fd_pc),         .fd_ready_o (fd_ready),
      .rs1_addr_o      (rs1_addr),      .rs2_addr_o (rs2_addr),
      .rs1_data_i      (rs1_data),      .rs2_data_i (rs2_data),
      .br_taken_o      (br_taken),      .br_target_o (br_target),
      .dx_ready_i      (dx_ready),      .dx_valid_o (dx_valid),
      .dx_alu_op_o     (dx_alu_op),     .dx_op_a_o  (dx_op_a),
      .dx_op_b_o       (dx_op_b),       .dx_store_data_o (dx_store_data),
      .dx_rd_o         (dx_rd),         .dx_wb_en_o (dx_wb_en),
      .dx_load_o       (dx_load),       .dx_store_o (dx_store)
   );

   cpu_execute execute0 (
      .clk             (clk),           .rst_i        (rst_i),
      .dx_valid_i      (dx_valid),      .dx_alu_op_i  (dx_alu_op),
      .dx_op_a_i       (dx_op_a),       .dx_op_b_i    (dx_op_b),
      .dx_store_data_i (dx_store_data), .dx_rd_i      (dx_rd),
      .dx_wb_en_i      (dx_wb_en),      .dx_load_i    (dx_load),
      .dx_store_i      (dx_store),      .dx_ready_o   (dx_ready),
      .wb_we_o         (wb_we),         .wb_addr_o    (wb_addr),
      .wb_data_o       (wb_data),
      .dbus_ack_i      (dbus_ack_i),    .dbus_rdata_i (dbus_rdata_i),
      .dbus_req_o      (dbus_req_o),    .dbus_we_o    (dbus_we_o),
      .dbus_addr_o     (dbus_addr_o),   .dbus_wdata_o (dbus_wdata_o)
   );

endmodule

/* rtl/cpu_execute.sv */
`timescale 1ns/100ps

module cpu_execute import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   // From decode
   input  logic     dx_valid_i,
   input  alu_op_t  dx_alu_op_i,
   input  word_t    dx_op_a_i,
   input  word_t    dx_op_b_i,
   input  word_t    dx_store_data_i,
   input  reg_idx_t dx_rd_i,
   input  logic     dx_wb_en_i,
   input  logic     dx_load_i,
   input  logic     dx_store_i,
   output logic     dx_ready_o,
   // Write-back
   output logic     wb_we_o,
   output reg_idx_t wb_addr_o,
   output word_t    wb_data_o,
   // Data bus
   input  logic     dbus_ack_i,
   input  word_t    dbus_rdata_i,
   output logic     dbus_req_o,
   output logic     dbus_we_o,
   output addr_t    dbus_addr_o,
   output word_t    dbus_wdata_o
);

   exec_state_t state_q;
   exec_state_t state_d;
   word_t       alu_res;                          // Also the memory address
   logic        mem_op;                           // Load or store present
   logic        mem_done;                         // Access completes this edge

   //////////////////////////////////////////////////////////////////////
   // ALU
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (dx_alu_op_i)
         ALU_ADD:  alu_res = dx_op_a_i + dx_op_b_i;
         ALU_SUB:  alu_res = dx_op_a_i - dx_op_b_i;
         ALU_AND:  alu_res = dx_op_a_i & dx_op_b_i;
         ALU_OR:   alu_res = dx_op_a_i | dx_op_b_i;
         ALU_XOR:  alu_res = dx_op_a_i ^ dx_op_b_i;
         ALU_PASS: alu_res = dx_op_b_i;
         default:  alu_res = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Data bus FSM
   //////////////////////////////////////////////////////////////////////

   assign mem_op   = dx_valid_i && (dx_load_i || dx_store_i);
   assign mem_done = dbus_req_o && dbus_ack_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         EX_IDLE: begin
            if (mem_op && !dbus_ack_i) begin
               state_d = EX_MEM_WAIT;             // No ack in first cycle
            end
         end
         EX_MEM_WAIT: begin
            if (dbus_ack_i) begin
               state_d = EX_IDLE;
            end
         end
         default: state_d = EX_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= EX_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Request fields come straight from the held decode register
   assign dbus_req_o   = mem_op || (state_q == EX_MEM_WAIT);
   assign dbus_we_o    = dx_store_i;
   assign dbus_addr_o  = alu_res;
   assign dbus_wdata_o = dx_store_data_i;

   assign dx_ready_o = ((state_q == EX_IDLE) && !mem_op) || mem_done;

   // ALU result retires now, load data on its ack
   assign wb_we_o   = dx_valid_i && dx_wb_en_i && (!dx_load_i || mem_done);
   assign wb_addr_o = dx_rd_i;
   assign wb_data_o = dx_load_i ? dbus_rdata_i : alu_res;

endmodule

/* rtl/cpu_decode.sv */
`timescale 1ns/100ps

module cpu_decode import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   // From fetch
   input  logic     fd_valid_i,
   input  insn_t    fd_insn_i,
   input  addr_t    fd_pc_i,
   output logic     fd_ready_o,
   // Register file reads
   output reg_idx_t rs1_addr_o,
   output reg_idx_t rs2_addr_o,
   input  word_t    rs1_data_i,
   input  word_t    rs2_data_i,
   // Redirect to fetch
   output logic     br_taken_o,
   output addr_t    br_target_o,
   // To execute
   input  logic     dx_ready_i,
   output logic     dx_valid_o,
   output alu_op_t  dx_alu_op_o,
   output word_t    dx_op_a_o,
   output word_t    dx_op_b_o,
   output word_t    dx_store_data_o,
   output reg_idx_t dx_rd_o,
   output logic     dx_wb_en_o,
   output logic     dx_load_o,
   output logic     dx_store_o
);

   logic [3:0] opcode;
   reg_idx_t   rd;
   word_t      imm_ext;                           // Sign-extended imm16
   alu_op_t    alu_op;
   logic       use_imm;                           // Operand B from immediate
   logic       wb_en;
   logic       is_load;
   logic       is_store;
   logic       is_beq;
   logic       fd_xfer;                           // Handing instruction to execute
   logic       dx_valid_q;

   // Field split
   assign opcode     = fd_insn_i[31:28];
   assign rd         = fd_insn_i[27:24];
   assign rs1_addr_o = fd_insn_i[23:20];
   assign rs2_addr_o = fd_insn_i[19:16];
   assign imm_ext    = {{16{fd_insn_i[15]}}, fd_insn_i[15:0]};

   // Opcode to control
   always_comb begin
      alu_op   = ALU_PASS;                        // NOP default
      use_imm  = 1'b0;
      wb_en    = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      is_beq   = 1'b0;
      case (opcode)
         OP_ADD:  begin alu_op = ALU_ADD; wb_en = 1'b1; end
         OP_SUB:  begin alu_op = ALU_SUB; wb_en = 1'b1; end
         OP_AND:  begin alu_op = ALU_AND; wb_en = 1'b1; end
         OP_OR:   begin alu_op = ALU_OR;  wb_en = 1'b1; end
         OP_XOR:  begin alu_op = ALU_XOR; wb_en = 1'b1; end
         OP_ADDI: begin alu_op = ALU_ADD; use_imm = 1'b1; wb_en = 1'b1; end
         OP_LDW:  begin alu_op = ALU_ADD; use_imm = 1'b1; wb_en = 1'b1; is_load = 1'b1; end
         OP_STW:  begin alu_op = ALU_ADD; use_imm = 1'b1; is_store = 1'b1; end
         OP_BEQ:  is_beq = 1'b1;                  // Travels on as a NOP
         default: ;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Branch resolve
   //////////////////////////////////////////////////////////////////////

   assign fd_ready_o  = !dx_valid_q || dx_ready_i;
   assign fd_xfer     = fd_valid_i && fd_ready_o;
   assign br_taken_o  = fd_xfer && is_beq && (rs1_data_i == rs2_data_i); // One-cycle pulse
   assign br_target_o = fd_pc_i + 32'd4 + {imm_ext[29:0], 2'b00};

   //////////////////////////////////////////////////////////////////////
   // Decode-to-execute register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst_i) begin
         dx_valid_q <= 1'b0;
      end else if (fd_ready_o) begin
         dx_valid_q <= fd_valid_i;                // Bubble when fetch is empty
      end
   end

   always_ff @(posedge clk) begin
      if (fd_xfer) begin
         dx_alu_op_o     <= alu_op;
         dx_op_a_o       <= rs1_data_i;
         dx_op_b_o       <= use_imm ? imm_ext : rs2_data_i;
         dx_store_data_o <= rs2_data_i;
         dx_rd_o         <= rd;
         dx_wb_en_o      <= wb_en && (rd != '0); // r0 writes dropped here
         dx_load_o       <= is_load;
         dx_store_o      <= is_store;
      end
   end

   assign dx_valid_o = dx_valid_q;

endmodule

/* rtl/cpu_fetch.sv */
`timescale 1ns/100ps

module cpu_fetch import cpu_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   // Instruction bus
   input  logic  ibus_valid_i,
   input  insn_t ibus_insn_i,
   output addr_t ibus_addr_o,
   output logic  ibus_ready_o,
   // To decode
   input  logic  fd_ready_i,
   output logic  fd_valid_o,
   output insn_t fd_insn_o,
   output addr_t fd_pc_o,
   // Redirect from decode
   input  logic  br_taken_i,
   input  addr_t br_target_i
);

   addr_t pc_q;                                   // Address on the bus
   logic  fd_valid_q;
   insn_t fd_insn_q;
   addr_t fd_pc_q;
   logic  accept;                                 // Instruction taken this edge

   assign ibus_addr_o  = pc_q;
   assign ibus_ready_o = !fd_valid_q || fd_ready_i; // Room once decode drains us
   assign accept       = ibus_valid_i && ibus_ready_o;

   //////////////////////////////////////////////////////////////////////
   // PC and stage valid
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pc_q       <= RESET_PC;
         fd_valid_q <= 1'b0;
      end else if (br_taken_i) begin
         pc_q       <= br_target_i;               // Redirect wins over accept
         fd_valid_q <= 1'b0;                      // Drop wrong-path fetch
      end else if (accept) begin
         pc_q       <= pc_q + 32'd4;
         fd_valid_q <= 1'b1;
      end else if (fd_ready_i) begin
         fd_valid_q <= 1'b0;                      // Drained with nothing new
      end
   end

   // Payload of the fetch-to-decode register
   always_ff @(posedge clk) begin
      if (accept) begin
         fd_insn_q <= ibus_insn_i;
         fd_pc_q   <= pc_q;                       // PC the word belongs to
      end
   end

   assign fd_valid_o = fd_valid_q;
   assign fd_insn_o  = fd_insn_q;
   assign fd_pc_o    = fd_pc_q;

endmodule

/* rtl/cpu_regfile.sv */
`timescale 1ns/100ps

module cpu_regfile import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   input  reg_idx_t rs1_addr_i,
   input  reg_idx_t rs2_addr_i,
   input  logic     we_i,
   input  reg_idx_t waddr_i,
   input  word_t    wdata_i,
   output word_t    rs1_data_o,
   output word_t    rs2_data_o
);

   word_t regs_q [NUM_REGS];                      // Entry 0 never written

   // Write port
   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;                      // Known state for every program
         end
      end else if (we_i && (waddr_i != '0)) begin
         regs_q[waddr_i] <= wdata_i;
      end
   end

   // One read port with r0 forced and write bypass
   function automatic word_t read_port(input reg_idx_t addr);
      word_t data;
      if (addr == '0) begin
         data = '0;                               // r0 hardwired
      end else if (we_i && (waddr_i == addr)) begin
         data = wdata_i;                          // Bypass value landing this edge
      end else begin
         data = regs_q[addr];
      end
      return data;
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
   end

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths and types
   //////////////////////////////////////////////////////////////////////

   localparam int NUM_REGS = 16;                  // r0 plus fifteen writable

   typedef logic [31:0]                   word_t;     // Data word
   typedef logic [31:0]                   addr_t;     // Byte address
   typedef logic [31:0]                   insn_t;     // Fixed 32-bit instruction
   typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;  // Register number
   typedef logic [2:0]                    alu_op_t;   // Internal ALU function

   localparam addr_t RESET_PC = 32'h0000_0000;    // First fetch address

   //////////////////////////////////////////////////////////////////////
   // Opcodes in insn[31:28]
   //////////////////////////////////////////////////////////////////////

   // Codes left unlisted execute as NOP, zero included
   localparam logic [3:0] OP_ADD  = 4'h1;         // rd = rs1 + rs2
   localparam logic [3:0] OP_SUB  = 4'h2;         // rd = rs1 - rs2
   localparam logic [3:0] OP_AND  = 4'h3;
   localparam logic [3:0] OP_OR   = 4'h4;
   localparam logic [3:0] OP_XOR  = 4'h5;
   localparam logic [3:0] OP_ADDI = 4'h6;         // rd = rs1 + sext(imm)
   localparam logic [3:0] OP_LDW  = 4'h7;         // rd = mem[rs1 + imm]
   localparam logic [3:0] OP_STW  = 4'h8;         // mem[rs1 + imm] = rs2
   localparam logic [3:0] OP_BEQ  = 4'h9;         // pc + 4 + 4*imm if equal

   // ALU functions
   localparam alu_op_t ALU_ADD  = 3'd0;
   localparam alu_op_t ALU_SUB  = 3'd1;
   localparam alu_op_t ALU_AND  = 3'd2;
   localparam alu_op_t ALU_OR   = 3'd3;
   localparam alu_op_t ALU_XOR  = 3'd4;
   localparam alu_op_t ALU_PASS = 3'd5;           // Result is operand B

   // Execute data bus FSM
   typedef enum logic {
      EX_IDLE,                                    // No access outstanding
      EX_MEM_WAIT                                 // Request up, waiting for ack
   } exec_state_t;

endpackage
